// ==== tb.f ====
rs_pkg.sv
rs_if.sv
rs_alloc.sv
rs_entry.sv
rs_issue_select.sv
rs_alu.sv
tb_clkgen.sv
tb_rs_alu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rs_alu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the binary is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_rs_alu.sv ====
`timescale 1ns/1ps

module tb_rs_alu import rs_pkg::*; ();

  localparam int MAX_CYC = 400;                // about four times the whole run
  localparam logic [TAG_W-1:0] NO_TAG = 6'd63; // no instruction ever writes it

  logic clk, rst, full, issue_valid, issue_dest_valid, issue_specbit;
  logic disp_valid, disp_rdy_a, disp_rdy_b, disp_dest_valid, disp_specbit;
  logic br_valid, br_success;
  logic [TAG_W-1:0] disp_src_a, disp_src_b, disp_dest;
  logic [TAG_W-1:0] issue_src_a, issue_src_b, issue_dest;
  logic [DATA_W-1:0] disp_imm, issue_imm;
  logic [SPECTAG_W-1:0] disp_spectag, br_tag, issue_spectag;
  logic [AGE_W-1:0] disp_age;
  logic [DLY_W-1:0] disp_delay;
  alu_op_e disp_alu_op, issue_alu_op;

  // reference model, indexed by dest tag
  rs_payload_t exp_pl [2**TAG_W];
  logic [2**TAG_W-1:0] exp_live, exp_spec, issued;
  int iss_cyc [2**TAG_W];
  int cyc, live_cnt;
  logic started;
  integer seed;
  logic [TAG_W-1:0] next_tag, pt, prod, cons, tq;
  logic [TAG_W-1:0] c [4];
  logic [AGE_W-1:0] ages [4] = '{6'd30, 6'd28, 6'd31, 6'd29};
  int order [4] = '{1, 3, 0, 2};             // c index sorted by age
  logic [DLY_W-1:0] dly [3] = '{3'd0, 3'd2, 3'd5};

  tb_clkgen u_clk (.clk(clk), .rst(rst));
  rs_alu u_dut (.*);

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    $display("Done: errors found");
    $fatal(1, "stopping at first mismatch");
  endtask

  // drive one dispatch on a falling edge, record it unless it should be dropped
  task automatic dispatch(
    input  logic [TAG_W-1:0]     src_a,
    input  logic                 rdy_a,
    input  logic [SPECTAG_W-1:0] spectag,
    input  logic                 spec,
    input  logic [AGE_W-1:0]     age,
    input  logic [DLY_W-1:0]     delay,
    input  logic                 keep,
    output logic [TAG_W-1:0]     dest
  );
    rs_payload_t pl;
    dest          = next_tag;
    next_tag      = next_tag + 6'd1;
    pl.src_a      = src_a;
    pl.src_b      = TAG_W'($random(seed));   // src_b always ready
    pl.imm        = $random(seed);
    pl.dest       = dest;
    pl.dest_valid = 1'b1;
    pl.alu_op     = alu_op_e'(4'(($random(seed) & 32'h7fff) % 10));
    pl.spectag    = spectag;
    pl.age        = age;
    pl.delay      = delay;
    disp_src_a      = pl.src_a;
    disp_src_b      = pl.src_b;
    disp_imm        = pl.imm;
    disp_dest       = pl.dest;
    disp_dest_valid = pl.dest_valid;
    disp_alu_op     = pl.alu_op;
    disp_spectag    = pl.spectag;
    disp_age        = pl.age;
    disp_delay      = pl.delay;
    disp_rdy_a      = rdy_a;
    disp_rdy_b      = 1'b1;
    disp_specbit    = spec;
    disp_valid      = 1'b1;
    started         = 1'b1;
    if (keep)
    begin
      exp_pl[dest]   = pl;
      exp_spec[dest] = spec;
      exp_live[dest] = 1'b1;
      live_cnt++;
    end
    @(negedge clk);
    disp_valid = 1'b0;
  endtask

  task automatic resolve(input logic [SPECTAG_W-1:0] tag, input logic ok);
    br_valid   = 1'b1;
    br_success = ok;
    br_tag     = tag;
    for (int t = 0; t < 2**TAG_W; t++)
    begin
      if (exp_live[t] && exp_pl[t].spectag == tag)
      begin
        if (ok)
          exp_spec[t] = 1'b0;
        else if (exp_spec[t])
        begin
          exp_live[t] = 1'b0;   // mispredicted path is dropped
          live_cnt--;
        end
      end
    end
    @(negedge clk);
    br_valid = 1'b0;
  endtask

  task automatic wait_issue(input logic [TAG_W-1:0] tag);
    while (!issued[tag])
      @(negedge clk);
  endtask

  // outputs settled during the previous cycle are checked here
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (cyc > MAX_CYC)
    begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYC);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
    if (rst && !started)
      assert (!issue_valid && !full) else fail_check("issue_valid or full high after reset");
    if (rst && issue_valid)
    begin
      assert (exp_live[issue_dest])
        else fail_check($sformatf("unexpected issue of tag %0d", issue_dest));
      assert (issue_src_a == exp_pl[issue_dest].src_a && issue_src_b == exp_pl[issue_dest].src_b
              && issue_imm == exp_pl[issue_dest].imm && issue_alu_op == exp_pl[issue_dest].alu_op
              && issue_dest_valid == exp_pl[issue_dest].dest_valid
              && issue_spectag == exp_pl[issue_dest].spectag)
        else fail_check($sformatf("issue fields of tag %0d differ from dispatch", issue_dest));
      assert (issue_specbit == exp_spec[issue_dest])
        else fail_check($sformatf("issue_specbit wrong for tag %0d", issue_dest));
      exp_live[issue_dest] = 1'b0;
      issued[issue_dest]   = 1'b1;
      iss_cyc[issue_dest]  = cyc;
      live_cnt--;
    end
  end

  initial
  begin
    seed            = 32'hbdfb;
    cyc             = 0;
    live_cnt        = 0;
    started         = 1'b0;
    next_tag        = 6'd1;
    exp_live        = '0;
    exp_spec        = '0;
    issued          = '0;
    disp_valid      = 1'b0;
    disp_rdy_a      = 1'b0;
    disp_rdy_b      = 1'b0;
    disp_dest_valid = 1'b0;
    disp_specbit    = 1'b0;
    disp_src_a      = '0;
    disp_src_b      = '0;
    disp_dest       = '0;
    disp_imm        = '0;
    disp_spectag    = '0;
    disp_age        = '0;
    disp_delay      = '0;
    br_valid        = 1'b0;
    br_success      = 1'b0;
    br_tag          = '0;
    disp_alu_op     = ALU_ADD;
    @(posedge rst);
    repeat (3) @(negedge clk);

    dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd1, 3'd0, 1'b1, tq);   // both operands ready
    wait_issue(tq);

    for (int i = 0; i < N_ENT; i++)
      dispatch(NO_TAG, 1'b0, 5'd9, 1'b1, 6'(i + 2), 3'd0, 1'b1, tq);
    assert (full) else fail_check("full low with every entry busy");
    dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd0, 3'd0, 1'b0, tq);   // dropped while full
    repeat (4) @(negedge clk);
    resolve(5'd9, 1'b0);
    assert (!full) else fail_check("full still high after kill of tag 9");

    // four consumers of one producer wake in the same cycle
    pt = next_tag + 6'd4;
    for (int i = 0; i < 4; i++)
      dispatch(pt, 1'b0, 5'd0, 1'b0, ages[i], 3'd0, 1'b1, c[i]);
    dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd20, 3'd0, 1'b1, prod);
    for (int i = 0; i < 4; i++)
      wait_issue(c[i]);
    assert (iss_cyc[c[order[0]]] == iss_cyc[prod] + 1) else fail_check("oldest consumer late");
    for (int k = 0; k < 3; k++)
      assert (iss_cyc[c[order[k + 1]]] == iss_cyc[c[order[k]]] + 1)
        else fail_check($sformatf("age order broken at rank %0d", k + 1));

    foreach (dly[i])
    begin
      pt = next_tag + 6'd1;
      dispatch(pt, 1'b0, 5'd0, 1'b0, 6'd40, 3'd0, 1'b1, cons);
      dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd41, dly[i], 1'b1, prod);
      wait_issue(cons);
      assert (iss_cyc[cons] == iss_cyc[prod] + int'(dly[i]) + 1)
        else fail_check($sformatf("consumer issue spacing wrong for delay %0d", dly[i]));
    end

    // misprediction on tag 4
    pt = next_tag + 6'd4;
    dispatch(pt, 1'b0, 5'd4, 1'b1, 6'd50, 3'd0, 1'b1, tq);
    dispatch(pt, 1'b0, 5'd4, 1'b1, 6'd51, 3'd0, 1'b1, tq);
    dispatch(pt, 1'b0, 5'd6, 1'b1, 6'd52, 3'd0, 1'b1, c[0]);
    dispatch(pt, 1'b0, 5'd4, 1'b0, 6'd53, 3'd0, 1'b1, c[1]);   // not speculative
    resolve(5'd4, 1'b0);
    dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd49, 3'd0, 1'b1, prod);
    wait_issue(c[0]);
    wait_issue(c[1]);
    repeat (4) @(negedge clk);

    // correct prediction on tag 8
    pt = next_tag + 6'd2;
    dispatch(pt, 1'b0, 5'd8, 1'b1, 6'd60, 3'd0, 1'b1, c[0]);
    dispatch(pt, 1'b0, 5'd10, 1'b1, 6'd61, 3'd0, 1'b1, c[1]);
    resolve(5'd8, 1'b1);
    dispatch(6'd0, 1'b1, 5'd0, 1'b0, 6'd59, 3'd0, 1'b1, prod);
    wait_issue(c[0]);
    wait_issue(c[1]);
    repeat (2) @(negedge clk);

    if (live_cnt == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
      fail_check($sformatf("%0d dispatched instructions never issued", live_cnt));
  end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  // reset low for 16 cycles, released on a falling edge
  initial
  begin
    rst = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

// ==== rs_alu.sv ====
`timescale 1ns/1ps

module rs_alu import rs_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 disp_valid,
  input  logic [TAG_W-1:0]     disp_src_a,
  input  logic [TAG_W-1:0]     disp_src_b,
  input  logic [TAG_W-1:0]     disp_dest,
  input  logic                 disp_rdy_a,
  input  logic                 disp_rdy_b,
  input  logic [DATA_W-1:0]    disp_imm,
  input  logic                 disp_dest_valid,
  input  alu_op_e              disp_alu_op,
  input  logic [SPECTAG_W-1:0] disp_spectag,
  input  logic                 disp_specbit,
  input  logic [AGE_W-1:0]     disp_age,
  input  logic [DLY_W-1:0]     disp_delay,
  input  logic                 br_valid,
  input  logic                 br_success,
  input  logic [SPECTAG_W-1:0] br_tag,
  output logic                 full,
  output logic                 issue_valid,
  output logic [TAG_W-1:0]     issue_src_a,
  output logic [TAG_W-1:0]     issue_src_b,
  output logic [TAG_W-1:0]     issue_dest,
  output logic [DATA_W-1:0]    issue_imm,
  output logic                 issue_dest_valid,
  output alu_op_e              issue_alu_op,
  output logic [SPECTAG_W-1:0] issue_spectag,
  output logic                 issue_specbit
);

  rs_payload_t      disp_payload;
  rs_payload_t      issue_op;
  logic             wk_valid;
  logic [TAG_W-1:0] wk_tag;
  logic [DLY_W-1:0] wk_delay;

  rs_write_if wr_if ();
  rs_issue_if iss_if ();

  always_comb
  begin
    disp_payload.src_a      = disp_src_a;
    disp_payload.src_b      = disp_src_b;
    disp_payload.imm        = disp_imm;
    disp_payload.dest       = disp_dest;
    disp_payload.dest_valid = disp_dest_valid;
    disp_payload.alu_op     = disp_alu_op;
    disp_payload.spectag    = disp_spectag;
    disp_payload.age        = disp_age;
    disp_payload.delay      = disp_delay;
  end

  rs_alloc u_alloc (
    .disp_valid   (disp_valid),
    .disp_payload (disp_payload),
    .disp_rdy_a   (disp_rdy_a),
    .disp_rdy_b   (disp_rdy_b),
    .disp_specbit (disp_specbit),
    .iss          (iss_if),
    .wr           (wr_if),
    .full         (full)
  );

  genvar g;
  generate
    for (g = 0; g < N_ENT; g++)
    begin : g_ent
      rs_entry #(.IDX(g)) u_ent (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr_if),
        .iss        (iss_if),
        .wk_valid   (wk_valid),
        .wk_tag     (wk_tag),
        .wk_delay   (wk_delay),
        .br_valid   (br_valid),
        .br_success (br_success),
        .br_tag     (br_tag)
      );
    end
  endgenerate

  rs_issue_select u_sel (
    .clk           (clk),
    .rst           (rst),
    .iss           (iss_if),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_specbit (issue_specbit),
    .wk_valid      (wk_valid),
    .wk_tag        (wk_tag),
    .wk_delay      (wk_delay)
  );

  // age and delay stay internal
  assign issue_src_a      = issue_op.src_a;
  assign issue_src_b      = issue_op.src_b;
  assign issue_dest       = issue_op.dest;
  assign issue_imm        = issue_op.imm;
  assign issue_dest_valid = issue_op.dest_valid;
  assign issue_alu_op     = issue_op.alu_op;
  assign issue_spectag    = issue_op.spectag;

endmodule

// ==== rs_issue_select.sv ====
`timescale 1ns/1ps

module rs_issue_select import rs_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  rs_issue_if.select       iss,
  output logic             issue_valid,
  output rs_payload_t      issue_op,
  output logic             issue_specbit,
  output logic             wk_valid,
  output logic [TAG_W-1:0] wk_tag,
  output logic [DLY_W-1:0] wk_delay
);

  // compare tree in heap order, node 0 is the root
  logic               nd_v   [2*N_ENT-1];
  logic [AGE_W-1:0]   nd_age [2*N_ENT-1];
  logic [ENT_SEL-1:0] nd_idx [2*N_ENT-1];
  logic               pick_l;

  always_comb
  begin
    pick_l = 1'b0;
    for (int i = 0; i < N_ENT; i++)
    begin
      nd_v[N_ENT-1+i]   = iss.ready[i];
      nd_age[N_ENT-1+i] = iss.payloads[i].age;
      nd_idx[N_ENT-1+i] = ENT_SEL'(i);
    end
    for (int n = N_ENT - 2; n >= 0; n--)
    begin
      // equal ages go to the left child
      pick_l    = nd_v[2*n+1] && (!nd_v[2*n+2] || nd_age[2*n+1] <= nd_age[2*n+2]);
      nd_v[n]   = nd_v[2*n+1] || nd_v[2*n+2];
      nd_age[n] = pick_l ? nd_age[2*n+1] : nd_age[2*n+2];
      nd_idx[n] = pick_l ? nd_idx[2*n+1] : nd_idx[2*n+2];
    end
  end

  always_comb
  begin
    iss.grant = '0;
    if (nd_v[0])
      iss.grant[nd_idx[0]] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
      issue_valid <= 1'b0;
    else
      issue_valid <= nd_v[0];
  end

  // issue register, only loaded on a grant
  always_ff @(posedge clk)
  begin
    if (nd_v[0])
    begin
      issue_op      <= iss.payloads[nd_idx[0]];
      issue_specbit <= iss.specbits[nd_idx[0]];
    end
  end

  // tag broadcast goes out alongside the issued op
  assign wk_valid = issue_valid && issue_op.dest_valid;
  assign wk_tag   = issue_op.dest;
  assign wk_delay = issue_op.delay;

endmodule

// ==== rs_entry.sv ====
`timescale 1ns/1ps

module rs_entry import rs_pkg::*; #(
  parameter int IDX = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  rs_write_if.entry            wr,
  rs_issue_if.entry            iss,
  input  logic                 wk_valid,
  input  logic [TAG_W-1:0]     wk_tag,
  input  logic [DLY_W-1:0]     wk_delay,
  input  logic                 br_valid,
  input  logic                 br_success,
  input  logic [SPECTAG_W-1:0] br_tag
);

  rs_payload_t      pl;
  logic             busy;
  logic             specbit;
  logic [1:0]       waiting;        // source still waits for its tag
  logic [DLY_W-1:0] cnt [2];        // cycles left until operand is ready
  logic [TAG_W-1:0] src_tag [2];
  logic [TAG_W-1:0] new_tag [2];
  logic [1:0]       new_rdy;
  logic [1:0]       hit;
  logic [1:0]       new_hit;
  logic [1:0]       src_rdy;
  logic [DLY_W-1:0] wk_load;
  logic             we;
  logic             br_match;
  logic             kill;
  logic             disp_br_match;
  logic             disp_kill;

  assign we = wr.we[IDX];

  // countdown start, delay 0 never reaches the counter
  assign wk_load = (wk_delay == '0) ? '0 : wk_delay - 1'b1;

  always_comb
  begin
    src_tag[0] = pl.src_a;
    src_tag[1] = pl.src_b;
    new_tag[0] = wr.payload.src_a;
    new_tag[1] = wr.payload.src_b;
    new_rdy    = {wr.rdy_b, wr.rdy_a};
    for (int s = 0; s < 2; s++)
    begin
      hit[s]     = wk_valid && (wk_tag == src_tag[s]);
      new_hit[s] = wk_valid && (wk_tag == new_tag[s]);
      // a single cycle producer wakes the operand in the broadcast cycle
      src_rdy[s] = waiting[s] ? (hit[s] && wk_delay == '0) : (cnt[s] == '0);
    end
  end

  assign br_match      = br_valid && (br_tag == pl.spectag);
  assign kill          = br_match && !br_success && specbit;
  assign disp_br_match = br_valid && (br_tag == wr.payload.spectag);
  assign disp_kill     = disp_br_match && !br_success && wr.specbit;

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      busy    <= 1'b0;
      specbit <= 1'b0;
      waiting <= '0;
      cnt     <= '{default: '0};
    end
    else if (we)
    begin
      busy    <= !disp_kill;
      specbit <= wr.specbit && !disp_br_match;
      for (int s = 0; s < 2; s++)
      begin
        waiting[s] <= !new_rdy[s] && !new_hit[s];
        cnt[s]     <= (!new_rdy[s] && new_hit[s]) ? wk_load : '0;
      end
    end
    else
    begin
      if (iss.grant[IDX] || kill)
        busy <= 1'b0;
      if (br_match && br_success)
        specbit <= 1'b0;       // branch resolved correctly
      for (int s = 0; s < 2; s++)
      begin
        if (waiting[s] && hit[s])
        begin
          waiting[s] <= 1'b0;
          cnt[s]     <= wk_load;
        end
        else if (cnt[s] != '0)
          cnt[s] <= cnt[s] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (we)
      pl <= wr.payload;
  end

  assign iss.ready[IDX]    = busy && src_rdy[0] && src_rdy[1];
  assign iss.busy[IDX]     = busy;
  assign iss.payloads[IDX] = pl;
  assign iss.specbits[IDX] = specbit;

endmodule

// ==== rs_alloc.sv ====
`timescale 1ns/1ps

module rs_alloc import rs_pkg::*; (
  input  logic        disp_valid,
  input  rs_payload_t disp_payload,
  input  logic        disp_rdy_a,
  input  logic        disp_rdy_b,
  input  logic        disp_specbit,
  rs_issue_if.select  iss,          // only busy is looked at
  rs_write_if.alloc   wr,
  output logic        full
);

  logic [ENT_SEL-1:0] free_idx;
  logic               found;

  // priority encoder, lowest free index wins
  always_comb
  begin
    found    = 1'b0;
    free_idx = '0;
    for (int i = N_ENT - 1; i >= 0; i--)
    begin
      if (!iss.busy[i])
      begin
        found    = 1'b1;
        free_idx = ENT_SEL'(i);
      end
    end
  end

  always_comb
  begin
    wr.we = '0;
    if (disp_valid && found)   // dispatch under full is dropped
      wr.we[free_idx] = 1'b1;
  end

  assign wr.payload = disp_payload;
  assign wr.rdy_a   = disp_rdy_a;
  assign wr.rdy_b   = disp_rdy_b;
  assign wr.specbit = disp_specbit;

  assign full = !found;

endmodule

// ==== rs_if.sv ====
`timescale 1ns/1ps

// dispatch path from the allocator into the entries
interface rs_write_if import rs_pkg::*; ();

  logic [N_ENT-1:0] we;        // one-hot entry select
  rs_payload_t      payload;
  logic             rdy_a;     // operand already available
  logic             rdy_b;
  logic             specbit;

  modport alloc (output we, payload, rdy_a, rdy_b, specbit);
  modport entry (input we, payload, rdy_a, rdy_b, specbit);

endinterface

// entry status toward the select logic, grant back
interface rs_issue_if import rs_pkg::*; ();

  logic [N_ENT-1:0] ready;
  logic [N_ENT-1:0] busy;
  rs_payload_t      payloads [N_ENT];
  logic [N_ENT-1:0] specbits;
  logic [N_ENT-1:0] grant;     // at most one bit set

  modport entry (
    output ready, busy, payloads, specbits,
    input  grant
  );

  modport select (
    input  ready, busy, payloads, specbits,
    output grant
  );

endinterface

// ==== rs_pkg.sv ====
package rs_pkg;

  localparam int N_ENT     = 8;
  localparam int ENT_SEL   = 3;
  localparam int TAG_W     = 6;   // physical register tag
  localparam int DATA_W    = 32;
  localparam int SPECTAG_W = 5;
  localparam int AGE_W     = 6;   // smaller is older
  localparam int DLY_W     = 3;   // execution cycles minus one
  localparam int OP_W      = 4;

  typedef enum logic [OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  // fields carried from dispatch to issue
  typedef struct packed {
    logic [TAG_W-1:0]     src_a;
    logic [TAG_W-1:0]     src_b;
    logic [DATA_W-1:0]    imm;
    logic [TAG_W-1:0]     dest;
    logic                 dest_valid;
    alu_op_e              alu_op;
    logic [SPECTAG_W-1:0] spectag;
    logic [AGE_W-1:0]     age;
    logic [DLY_W-1:0]     delay;    // wakeup latency code of this op
  } rs_payload_t;

endpackage
